//--- cargoPkg.sv
package cargoPkg;

    typedef logic [1:0] floorT;

    // object type 00 means no real cargo
    typedef enum logic [1:0] {
        objNone    = 2'b00,
        objBox     = 2'b01,
        objPallet  = 2'b10,
        objFragile = 2'b11
    } objTypeT;

    // queue word: isOrigin, type, origin floor, target floor
    typedef struct packed {
        logic    isOrigin;
        objTypeT objType;
        floorT   origin;
        floorT   target;
    } stopEntryT;

    typedef enum logic [2:0] {
        stIdle,
        stDecide,
        stMoveUp,
        stMoveDown,
        stDoor,
        stRetire
    } ctrlStateT;

    typedef enum logic [1:0] {
        moveStop,
        moveUp,
        moveDown
    } motionT;

    typedef struct packed {
        logic      valid;
        stopEntryT entry;
    } stopDoneT;

    localparam int QUEUE_DEPTH = 16;
    localparam int QUEUE_AW    = 4;
    localparam int DOOR_CYCLES = 20;
    localparam int DWELL_W     = $clog2(DOOR_CYCLES);  // wide enough for DOOR_CYCLES-1

endpackage

//--- cargoBusPkg.sv
package cargoBusPkg;

    // wishbone classic, master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [1:0] adr;
        logic [7:0] dat;
    } wbReqT;

    // slave to master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wbRspT;

    localparam logic [1:0] ADDR_REQUEST = 2'd0;  // [1:0] origin, [3:2] dest, [5:4] type
    localparam logic [1:0] ADDR_CONTROL = 2'd1;  // bit 0 run
    localparam logic [1:0] ADDR_STATUS  = 2'd2;  // read only

    typedef struct packed {
        logic [1:0] floor;
        logic       doorOpen;
        logic       moving;
        logic [3:0] count;      // saturates at 15
    } statusT;

endpackage

//--- cargoRequestPort.sv
module cargoRequestPort import cargoPkg::*, cargoBusPkg::*; (
    input  logic            clock,
    input  logic            arstN,
    input  wbReqT           wbIn,
    input  logic            freeTwo,
    input  statusT          status,
    output wbRspT           wbOut,
    output logic            pushPair,
    output stopEntryT [1:0] pushEntries,
    output logic            runEnable
);

    logic       ackReg;
    logic       runReg;
    logic [5:0] lastReq;
    logic       busActive;
    logic       reqWrite;
    logic       ctrlWrite;
    objTypeT    reqType;
    floorT      reqOrigin;
    floorT      reqDest;

    assign busActive = wbIn.cyc && wbIn.stb;
    assign reqWrite  = wbIn.we && (wbIn.adr == ADDR_REQUEST);
    assign ctrlWrite = wbIn.we && (wbIn.adr == ADDR_CONTROL);

    assign reqOrigin = wbIn.dat[1:0];
    assign reqDest   = wbIn.dat[3:2];
    assign reqType   = objTypeT'(wbIn.dat[5:4]);

    // request writes wait for two free slots, everything else acks next cycle
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            ackReg <= 1'b0;
        end else begin
            ackReg <= busActive && !ackReg && (!reqWrite || freeTwo);
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            runReg <= 1'b0;
        end else if (ackReg && ctrlWrite) begin
            runReg <= wbIn.dat[0];
        end
    end

    always_ff @(posedge clock) begin
        if (ackReg && reqWrite) begin
            lastReq <= wbIn.dat[5:0];
        end
    end

    // type none is acked but never queued
    assign pushPair = ackReg && busActive && reqWrite && (reqType != objNone);

    assign pushEntries[0] = '{isOrigin: 1'b1, objType: reqType,
                              origin: reqOrigin, target: reqOrigin};
    assign pushEntries[1] = '{isOrigin: 1'b0, objType: reqType,
                              origin: reqOrigin, target: reqDest};

    assign runEnable = runReg;

    always_comb begin
        wbOut.ack = ackReg;
        case (wbIn.adr)
            ADDR_REQUEST: wbOut.dat = {2'b00, lastReq};
            ADDR_CONTROL: wbOut.dat = {7'd0, runReg};
            ADDR_STATUS:  wbOut.dat = status;
            default:      wbOut.dat = '0;
        endcase
    end

endmodule

//--- stopQueue.sv
module stopQueue import cargoPkg::*; (
    input  logic            clock,
    input  logic            arstN,
    input  logic            pushPair,
    input  stopEntryT [1:0] pushEntries,
    input  logic            popHead,
    output stopEntryT       head,
    output logic            empty,
    output logic            freeTwo,
    output logic [QUEUE_AW:0] count
);

    stopEntryT             mem [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0]   wrPtr;
    logic [QUEUE_AW-1:0]   wrNext;
    logic [QUEUE_AW-1:0]   rdPtr;
    logic [QUEUE_AW:0]     countReg;
    logic                  doPush;
    logic                  doPop;

    assign empty   = (countReg == '0);
    assign freeTwo = (countReg <= (QUEUE_AW + 1)'(QUEUE_DEPTH - 2));
    assign count   = countReg;

    // guard against overflow and popping an empty queue
    assign doPush = pushPair && freeTwo;
    assign doPop  = popHead && !empty;

    assign wrNext = wrPtr + 1'b1;  // wraps with the depth

    always_ff @(posedge clock) begin
        if (doPush) begin
            mem[wrPtr]  <= pushEntries[0];  // origin goes in first
            mem[wrNext] <= pushEntries[1];
        end
    end

    assign head = mem[rdPtr];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            countReg <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + QUEUE_AW'(2);
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   countReg <= countReg + (QUEUE_AW + 1)'(2);
                2'b11:   countReg <= countReg + 1'b1;  // net one entry added
                2'b01:   countReg <= countReg - 1'b1;
                default: countReg <= countReg;
            endcase
        end
    end

endmodule

//--- floorTracker.sv
module floorTracker import cargoPkg::*; (
    input  logic       clock,
    input  logic       arstN,
    input  logic [3:0] sensors,
    output floorT      floor,
    output logic       arrived
);

    logic  anyActive;
    logic  anyPrev;
    logic  riseEdge;
    floorT sensedFloor;

    assign anyActive = |sensors;
    assign riseEdge  = anyActive && !anyPrev;  // one per floor reached

    // one-hot to number, lowest bit wins on a bad pattern
    always_comb begin
        sensedFloor = floor;
        if (sensors[0])      sensedFloor = 2'd0;
        else if (sensors[1]) sensedFloor = 2'd1;
        else if (sensors[2]) sensedFloor = 2'd2;
        else if (sensors[3]) sensedFloor = 2'd3;
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            anyPrev <= 1'b0;
            floor   <= 2'd0;
            arrived <= 1'b0;
        end else begin
            anyPrev <= anyActive;
            arrived <= riseEdge;
            if (riseEdge) begin
                floor <= sensedFloor;
            end
        end
    end

endmodule

//--- smartCargoFd.sv
module smartCargoFd import cargoPkg::*, cargoBusPkg::*; (
    input  logic       clock,
    input  logic       arstN,
    input  wbReqT      wbIn,
    input  logic [3:0] sensors,
    input  logic       popHead,
    input  logic       startDoor,
    input  motionT     motion,
    output wbRspT      wbOut,
    output logic       runEnable,
    output logic       queueEmpty,
    output stopEntryT  headEntry,
    output motionT     headCmp,
    output logic       arrived,
    output logic       doorDone
);

    logic               pushPair;
    logic               freeTwo;
    stopEntryT [1:0]    pushEntries;
    logic [QUEUE_AW:0]  queueCount;
    floorT              floor;
    logic [DWELL_W-1:0] dwellCount;
    logic               doorBusy;
    statusT             status;

    cargoRequestPort u_requestPort (
        .clock       (clock),
        .arstN       (arstN),
        .wbIn        (wbIn),
        .freeTwo     (freeTwo),
        .status      (status),
        .wbOut       (wbOut),
        .pushPair    (pushPair),
        .pushEntries (pushEntries),
        .runEnable   (runEnable)
    );

    stopQueue u_stopQueue (
        .clock       (clock),
        .arstN       (arstN),
        .pushPair    (pushPair),
        .pushEntries (pushEntries),
        .popHead     (popHead),
        .head        (headEntry),
        .empty       (queueEmpty),
        .freeTwo     (freeTwo),
        .count       (queueCount)
    );

    floorTracker u_floorTracker (
        .clock   (clock),
        .arstN   (arstN),
        .sensors (sensors),
        .floor   (floor),
        .arrived (arrived)
    );

    // dwell timer, busy for exactly DOOR_CYCLES cycles after startDoor
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            dwellCount <= '0;
            doorBusy   <= 1'b0;
        end else if (startDoor) begin
            dwellCount <= DWELL_W'(DOOR_CYCLES - 1);
            doorBusy   <= 1'b1;
        end else if (doorBusy) begin
            if (dwellCount == '0) doorBusy <= 1'b0;
            else                  dwellCount <= dwellCount - 1'b1;
        end
    end

    assign doorDone = doorBusy && (dwellCount == '0);  // last open cycle

    // direction toward the head stop
    always_comb begin
        if (headEntry.target > floor)      headCmp = moveUp;
        else if (headEntry.target < floor) headCmp = moveDown;
        else                               headCmp = moveStop;
    end

    always_comb begin
        status.floor    = floor;
        status.doorOpen = doorBusy;
        status.moving   = (motion != moveStop);
        status.count    = queueCount[QUEUE_AW] ? '1 : queueCount[QUEUE_AW-1:0];
    end

endmodule

//--- smartCargoUc.sv
module smartCargoUc import cargoPkg::*; (
    input  logic      clock,
    input  logic      arstN,
    input  logic      runEnable,
    input  logic      queueEmpty,
    input  stopEntryT headEntry,
    input  motionT    headCmp,
    input  logic      arrived,
    input  logic      doorDone,
    output motionT    motion,
    output logic      doorOpen,
    output logic      startDoor,
    output logic      popHead,
    output stopDoneT  stopDone
);

    ctrlStateT state;
    ctrlStateT nextState;
    logic      stopValid;
    stopEntryT stopEntry;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                // run only gates new decisions from here
                if (runEnable && !queueEmpty) nextState = stDecide;
            end
            stDecide: begin
                case (headCmp)
                    moveUp:   nextState = stMoveUp;
                    moveDown: nextState = stMoveDown;
                    default:  nextState = stDoor;  // already at target
                endcase
            end
            stMoveUp, stMoveDown: begin
                if (arrived) nextState = stDecide;  // one floor at a time
            end
            stDoor: begin
                if (doorDone) nextState = stRetire;
            end
            stRetire: nextState = stIdle;
            default:  nextState = stIdle;
        endcase
    end

    assign startDoor = (state == stDecide) && (headCmp == moveStop);
    assign popHead   = (state == stRetire);
    assign doorOpen  = (state == stDoor);

    always_comb begin
        case (state)
            stMoveUp:   motion = moveUp;
            stMoveDown: motion = moveDown;
            default:    motion = moveStop;
        endcase
    end

    // served stop reported together with the door opening
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            stopValid <= 1'b0;
        end else begin
            stopValid <= startDoor;
        end
    end

    always_ff @(posedge clock) begin
        if (startDoor) begin
            stopEntry <= headEntry;
        end
    end

    assign stopDone.valid = stopValid;
    assign stopDone.entry = stopEntry;

endmodule

//--- smartCargo.sv
module smartCargo import cargoPkg::*, cargoBusPkg::*; (
    input  logic       clock,
    input  logic       arstN,
    input  wbReqT      wbIn,
    output wbRspT      wbOut,
    input  logic [3:0] sensors,
    output motionT     motion,
    output logic       doorOpen,
    output stopDoneT   stopDone
);

    logic      runEnable;
    logic      queueEmpty;
    stopEntryT headEntry;
    motionT    headCmp;
    logic      arrived;
    logic      doorDone;
    logic      popHead;
    logic      startDoor;

    smartCargoFd u_fd (
        .clock      (clock),
        .arstN      (arstN),
        .wbIn       (wbIn),
        .sensors    (sensors),
        .popHead    (popHead),
        .startDoor  (startDoor),
        .motion     (motion),
        .wbOut      (wbOut),
        .runEnable  (runEnable),
        .queueEmpty (queueEmpty),
        .headEntry  (headEntry),
        .headCmp    (headCmp),
        .arrived    (arrived),
        .doorDone   (doorDone)
    );

    smartCargoUc u_uc (
        .clock      (clock),
        .arstN      (arstN),
        .runEnable  (runEnable),
        .queueEmpty (queueEmpty),
        .headEntry  (headEntry),
        .headCmp    (headCmp),
        .arrived    (arrived),
        .doorDone   (doorDone),
        .motion     (motion),
        .doorOpen   (doorOpen),
        .startDoor  (startDoor),
        .popHead    (popHead),
        .stopDone   (stopDone)
    );

endmodule

//--- smartCargo_assertions.sv
module smartCargoAssertions import cargoPkg::*, cargoBusPkg::*; (
    input logic     clock,
    input logic     arstN,
    input wbReqT    wbIn,
    input wbRspT    wbOut,
    input motionT   motion,
    input logic     doorOpen,
    input stopDoneT stopDone
);

    int failCount = 0;  // assertion failures so far

    motionLegal: assert property (@(posedge clock) disable iff (!arstN)
        motion inside {moveStop, moveUp, moveDown})
        else begin
            failCount++;
            $error("motion command has an illegal encoding");
        end

    // car must not move with the door open
    stoppedWhileOpen: assert property (@(posedge clock) disable iff (!arstN)
        doorOpen |-> (motion == moveStop))
        else begin
            failCount++;
            $error("motor driven while the door is open");
        end

    ackInsideCycle: assert property (@(posedge clock) disable iff (!arstN)
        wbOut.ack |-> (wbIn.cyc && wbIn.stb))
        else begin
            failCount++;
            $error("ack outside a bus cycle");
        end

    doneWithDoor: assert property (@(posedge clock) disable iff (!arstN)
        stopDone.valid == $rose(doorOpen))
        else begin
            failCount++;
            $error("stopDone pulse does not line up with the door opening");
        end

endmodule

bind smartCargo smartCargoAssertions u_assertions (
    .clock    (clock),
    .arstN    (arstN),
    .wbIn     (wbIn),
    .wbOut    (wbOut),
    .motion   (motion),
    .doorOpen (doorOpen),
    .stopDone (stopDone)
);

//--- smartCargoTb.sv
module smartCargoTb import cargoPkg::*, cargoBusPkg::*; ();

    // worst stop is 3 floors of about 12 cycles each plus the dwell and a few control cycles
    localparam int STOP_WORST     = 3 * 12 + DOOR_CYCLES + 4;
    localparam int STOP_BUDGET    = 44;  // stops over all tests rounded up
    localparam int TIMEOUT_CYCLES = STOP_BUDGET * STOP_WORST * 8;
    localparam int WRITE_WAIT     = 4 * STOP_WORST;  // a held write waits for two pops

    logic       clock   = 1'b0;
    logic       arstN   = 1'b0;
    wbReqT      wbIn    = '0;
    wbRspT      wbOut;
    logic [3:0] sensors = 4'b0001;  // car parked at floor 0
    motionT     motion;
    logic       doorOpen;
    stopDoneT   stopDone;

    stopEntryT expectedStops[$];
    stopEntryT monitorStop;
    floorT     expFloor        = '0;
    int        servedCount     = 0;
    int        doorRun         = 0;
    int        errorCount      = 0;
    int        checkCount      = 0;
    int        testCount       = 0;
    int        failedTests     = 0;
    int        testStartErrors = 0;
    int        cycleCount      = 0;
    string     curTest         = "none";

    floorT     shaftFloor = '0;
    floorT     nextFloor  = '0;
    int        holdCount  = 0;
    int        gapCount   = 0;
    logic      inGap      = 1'b0;

    smartCargo u_dut (
        .clock    (clock),
        .arstN    (arstN),
        .wbIn     (wbIn),
        .wbOut    (wbOut),
        .sensors  (sensors),
        .motion   (motion),
        .doorOpen (doorOpen),
        .stopDone (stopDone)
    );

    always #4 clock = ~clock;

    // the car leaves a floor after 6 cycles of drive and reaches the next after 4 dark cycles
    always @(posedge clock) begin
        if (arstN) begin
            if (inGap) begin
                if (gapCount == 3) begin
                    inGap      <= 1'b0;
                    shaftFloor <= nextFloor;
                    sensors    <= 4'b0001 << nextFloor;
                end else begin
                    gapCount <= gapCount + 1;
                end
            end else if (motion == moveStop) begin
                holdCount <= 0;
            end else if (holdCount == 5) begin
                holdCount <= 0;
                gapCount  <= 0;
                inGap     <= 1'b1;
                sensors   <= 4'b0000;
                nextFloor <= (motion == moveUp) ? shaftFloor + 2'd1 : shaftFloor - 2'd1;
            end else begin
                holdCount <= holdCount + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            printCounts();
            $display("sim failed");
            $finish;
        end
    end

    // scoreboard and door timing
    always @(negedge clock) begin
        if (arstN) begin
            if (stopDone.valid) begin
                if (expectedStops.size() == 0) begin
                    reportError("stopDone reported with no stop expected");
                end else begin
                    monitorStop = expectedStops.pop_front();
                    checkStop(monitorStop, stopDone.entry);
                    expFloor = monitorStop.target;
                    servedCount++;
                end
            end
            if (doorOpen) begin
                doorRun++;
            end else if (doorRun != 0) begin
                checkNumber("door open cycles", DOOR_CYCLES, doorRun);
                doorRun = 0;
            end
        end
    end

    function automatic stopEntryT makeStop(input logic isOrigin, input objTypeT t,
                                           input floorT origin, input floorT target);
        stopEntryT s;
        s.isOrigin = isOrigin;
        s.objType  = t;
        s.origin   = origin;
        s.target   = target;
        return s;
    endfunction

    function automatic statusT makeStatus(input floorT floor, input logic door,
                                          input logic moving, input int count);
        statusT s;
        s.floor    = floor;
        s.doorOpen = door;
        s.moving   = moving;
        s.count    = (count > 15) ? 4'd15 : 4'(count);  // saturating count field
        return s;
    endfunction

    function automatic logic [7:0] requestData(input objTypeT t, input floorT o, input floorT d);
        return {2'b00, t, d, o};
    endfunction

    function automatic string stopText(input stopEntryT s);
        return $sformatf("{isOrigin %0b, type %0d, origin %0d, target %0d}",
                         s.isOrigin, s.objType, s.origin, s.target);
    endfunction

    function automatic string statusText(input statusT s);
        return $sformatf("{floor %0d, doorOpen %0b, moving %0b, count %0d}",
                         s.floor, s.doorOpen, s.moving, s.count);
    endfunction

    task automatic reportError(input string msg);
        errorCount++;
        $display("ERROR %s: %s", curTest, msg);
    endtask

    task automatic checkStop(input stopEntryT expected, input stopEntryT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: stop expected %s actual %s", curTest,
                     stopText(expected), stopText(actual));
        end
    endtask

    task automatic checkStatus(input statusT expected, input statusT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: status expected %s actual %s", curTest,
                     statusText(expected), statusText(actual));
        end
    endtask

    task automatic checkMotion(input motionT expected, input motionT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s: motion expected %0d actual %0d", curTest, expected, actual);
        end
    endtask

    task automatic checkNumber(input string what, input int expected, input int actual);
        checkCount++;
        if (actual != expected) begin
            errorCount++;
            $display("MISMATCH %s: %s expected %0d actual %0d", curTest, what, expected, actual);
        end
    endtask

    // runs one bus cycle and drops it after ack or after maxWait cycles
    task automatic busCycle(input logic we, input logic [1:0] adr, input logic [7:0] dat,
                            input int maxWait, output logic acked, output logic [7:0] rdData);
        int waited;
        acked  = 1'b0;
        rdData = '0;
        waited = 0;
        @(posedge clock);
        wbIn <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        while (!acked && waited < maxWait) begin
            @(negedge clock);
            if (wbOut.ack) begin
                acked  = 1'b1;
                rdData = wbOut.dat;
            end
            waited++;
        end
        @(posedge clock);
        wbIn <= '0;
    endtask

    task automatic wbWrite(input logic [1:0] adr, input logic [7:0] dat, input int maxWait,
                           output logic acked);
        logic [7:0] unused;
        busCycle(1'b1, adr, dat, maxWait, acked, unused);
    endtask

    task automatic wbRead(input logic [1:0] adr, output logic [7:0] data);
        logic acked;
        busCycle(1'b0, adr, 8'h00, 10, acked, data);
        if (!acked) reportError("read was not acknowledged");
    endtask

    task automatic writeReg(input logic [1:0] adr, input logic [7:0] dat);
        logic acked;
        wbWrite(adr, dat, 10, acked);
        if (!acked) reportError("register write was not acknowledged");
    endtask

    task automatic readStatus(output statusT s);
        logic [7:0] data;
        wbRead(ADDR_STATUS, data);
        s = statusT'(data);
    endtask

    task automatic submitRequest(input objTypeT t, input floorT o, input floorT d,
                                 input int maxWait);
        logic acked;
        wbWrite(ADDR_REQUEST, requestData(t, o, d), maxWait, acked);
        if (!acked) begin
            reportError($sformatf("request %0d to %0d was not acknowledged", o, d));
        end else if (t != objNone) begin
            expectedStops.push_back(makeStop(1'b1, t, o, o));  // origin stop first
            expectedStops.push_back(makeStop(1'b0, t, o, d));
        end
    endtask

    task automatic waitServed(input int target, input int maxCycles);
        int waited;
        waited = 0;
        while (servedCount < target && waited < maxCycles) begin
            @(posedge clock);
            waited++;
        end
        if (servedCount < target) begin
            reportError($sformatf("only %0d of %0d stops were served", servedCount, target));
        end
    endtask

    task automatic waitDrained();
        statusT s;
        logic   drained;
        int     tries;
        drained = 1'b0;
        tries   = 0;
        while (!drained && tries < 200) begin
            readStatus(s);
            drained = (s.count == 0) && !s.doorOpen && !s.moving && (expectedStops.size() == 0);
            tries++;
        end
        if (!drained) reportError("queue did not drain");
    endtask

    task automatic startTest(input string name);
        curTest         = name;
        testStartErrors = errorCount;
        testCount++;
    endtask

    task automatic finishTest();
        int errs;
        errs = errorCount - testStartErrors;
        if (errs != 0) failedTests++;
        $display("test %s: %s (%0d errors)", curTest, (errs == 0) ? "ok" : "FAIL", errs);
    endtask

    task automatic printCounts();
        $display("tests %0d, failing tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 testCount, failedTests, checkCount, errorCount, u_dut.u_assertions.failCount);
    endtask

    task automatic testResetState();
        statusT s;
        startTest("resetState");
        readStatus(s);
        checkStatus(makeStatus(2'd0, 1'b0, 1'b0, 0), s);
        @(negedge clock);
        checkMotion(moveStop, motion);
        finishTest();
    endtask

    task automatic testSingleRequest();
        statusT     s;
        logic [7:0] data;
        int         base;
        startTest("singleRequest");
        base = servedCount;
        writeReg(ADDR_CONTROL, 8'h01);
        wbRead(ADDR_CONTROL, data);
        checkNumber("run readback", 1, data);
        submitRequest(objBox, 2'd2, 2'd1, 10);
        wbRead(ADDR_REQUEST, data);
        checkNumber("request readback", requestData(objBox, 2'd2, 2'd1), data);
        waitServed(base + 1, 4 * STOP_WORST);
        readStatus(s);
        checkStatus(makeStatus(2'd2, 1'b1, 1'b0, 2), s);  // head still queued while open
        waitServed(base + 2, 4 * STOP_WORST);
        readStatus(s);
        checkStatus(makeStatus(2'd1, 1'b1, 1'b0, 1), s);
        waitDrained();
        finishTest();
    endtask

    task automatic testNoneRequest();
        statusT s;
        int     base;
        startTest("noneRequest");
        base = servedCount;
        submitRequest(objNone, 2'd3, 2'd0, 10);
        readStatus(s);
        checkStatus(makeStatus(expFloor, 1'b0, 1'b0, 0), s);
        repeat (2 * STOP_WORST) @(posedge clock);  // long enough for a stop to show up
        checkNumber("stops served", base, servedCount);
        @(negedge clock);
        checkMotion(moveStop, motion);
        finishTest();
    endtask

    task automatic testBackPressure();
        statusT     s;
        logic       acked;
        logic [7:0] heldReq;
        int         base;
        startTest("backPressure");
        writeReg(ADDR_CONTROL, 8'h00);
        for (int i = 0; i < 8; i++) begin
            submitRequest(objTypeT'(2'(i % 3 + 1)), 2'(i % 4), 2'(3 - i % 4), 10);
        end
        readStatus(s);
        checkStatus(makeStatus(expFloor, 1'b0, 1'b0, 16), s);
        heldReq = requestData(objPallet, 2'd0, 2'd3);
        wbWrite(ADDR_REQUEST, heldReq, 40, acked);  // gives up and drops the cycle
        if (acked) reportError("request write acked while the queue was full");
        base = servedCount;
        writeReg(ADDR_CONTROL, 8'h01);
        wbWrite(ADDR_REQUEST, heldReq, WRITE_WAIT, acked);
        if (!acked) begin
            reportError("held request write was never acknowledged");
        end else begin
            // each pop follows a served stop, and a pair needs two pops
            if (servedCount < base + 2) begin
                reportError("held request acked before two stops were served");
            end
            expectedStops.push_back(makeStop(1'b1, objPallet, 2'd0, 2'd0));
            expectedStops.push_back(makeStop(1'b0, objPallet, 2'd0, 2'd3));
        end
        waitServed(base + 18, 24 * STOP_WORST);
        waitDrained();
        finishTest();
    endtask

    task automatic testRandomRequests();
        objTypeT t;
        floorT   o;
        floorT   d;
        int      base;
        startTest("randomRequests");
        base = servedCount;
        for (int i = 0; i < 12; i++) begin
            t = objTypeT'(2'($urandom_range(3, 1)));  // never objNone
            o = 2'($urandom_range(3, 0));
            d = 2'($urandom_range(3, 0));
            submitRequest(t, o, d, WRITE_WAIT);
        end
        waitServed(base + 24, 30 * STOP_WORST);
        waitDrained();
        finishTest();
    endtask

    initial begin
        int totalErrors;
        void'($urandom(91608));
        repeat (3) @(posedge clock);
        arstN <= 1'b1;
        testResetState();
        testSingleRequest();
        testNoneRequest();
        testBackPressure();
        testRandomRequests();
        totalErrors = errorCount + u_dut.u_assertions.failCount;
        printCounts();
        if (totalErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- smartCargo.f
cargoPkg.sv
cargoBusPkg.sv
cargoRequestPort.sv
stopQueue.sv
floorTracker.sv
smartCargoFd.sv
smartCargoUc.sv
smartCargo.sv
smartCargo_assertions.sv
smartCargoTb.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module smartCargoTb \
    -f smartCargo.f -o smartCargoSim || exit 1
result=$(./obj_dir/smartCargoSim +verilator+error+limit+1000)
echo "$result"
echo "$result" | grep -qx "sim passed" && exit 0 || exit 1
